//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module controlUnitTb -f all.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/VcontrolUnitTb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

//--- all.f
design/controlPkg.sv
design/controlIf.sv
design/mainDecoder.sv
design/aluOpDecoder.sv
design/systemDecoder.sv
design/trapArbiter.sv
design/controlUnit.sv
test/controlUnit_properties.sv
test/controlUnitTb.sv

//--- design/aluOpDecoder.sv
`timescale 1ns/1ps

module aluOpDecoder
	import controlPkg::*;
(
	input  logic [31:0]    instr,
	datapathCtrlIf.decoder dp,
	output logic           functIllegal
);

	opcodeT opcode;
	funct3T funct3;
	funct7T funct7;

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = funct7T'(instr[31:25]);

	// base integer table, shared by OP-IMM and R-type
	function automatic aluOpT baseOp(input funct3T f3, input logic alt, input logic isReg);
		aluOpT op;
		op = ALU_NULL;
		case (f3)
			FUNCT3_ADD:  op = (alt && isReg) ? ALU_SUB : ALU_ADD; // no subi
			FUNCT3_SLL:  op = ALU_SLL;
			FUNCT3_SLT:  op = ALU_SLT;
			FUNCT3_SLTU: op = ALU_SLTU;
			FUNCT3_XOR:  op = ALU_XOR;
			FUNCT3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
			FUNCT3_OR:   op = ALU_OR;
			FUNCT3_AND:  op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb
	begin
		dp.aluControl = ALU_NULL;
		functIllegal = 1'b0;
		case (opcode)
			OPC_OPIMM:
				dp.aluControl = baseOp(funct3, funct7 == FUNCT7_ALT, 1'b0);
			OPC_RTYPE:
			begin
				case (funct7)
					FUNCT7_BASE, FUNCT7_ALT:
						dp.aluControl = baseOp(funct3, funct7 == FUNCT7_ALT, 1'b1);
					FUNCT7_MULDIV:
					begin
						case (funct3)
							FUNCT3_MUL:    dp.aluControl = ALU_MUL;
							FUNCT3_MULH:   dp.aluControl = ALU_MULH;
							FUNCT3_MULHSU: dp.aluControl = ALU_MULHSU;
							FUNCT3_MULHU:  dp.aluControl = ALU_MULHU;
							FUNCT3_DIV:    dp.aluControl = ALU_DIV;
							FUNCT3_DIVU:   dp.aluControl = ALU_DIVU;
							FUNCT3_REM:    dp.aluControl = ALU_REM;
							FUNCT3_REMU:   dp.aluControl = ALU_REMU;
						endcase
					end
					default:
						functIllegal = 1'b1; // unknown funct7
				endcase
			end
			OPC_LOAD, OPC_STORE, OPC_AUIPC, OPC_BRANCH, OPC_JAL, OPC_JALR:
				dp.aluControl = ALU_ADD; // address or target sum
			OPC_LUI:
				dp.aluControl = ALU_LUI;
			default:
				dp.aluControl = ALU_NULL;
		endcase
	end

endmodule

//--- design/controlIf.sv
`timescale 1ns/1ps

interface datapathCtrlIf
	import controlPkg::*;
();
	logic origAUla;
	logic origBUla;
	logic regWrite;
	logic memWrite;
	logic memRead;
	aluOpT aluControl;
	mem2RegT mem2Reg;
	pcSourceT origPc;
	logic isLoad; // class flags for the fault checks
	logic isStore;

	modport decoder
	(
		output origAUla, origBUla, regWrite, memWrite, memRead,
		output aluControl, mem2Reg, origPc, isLoad, isStore
	);

	modport arbiter
	(
		input origAUla, origBUla, regWrite, memWrite, memRead,
		input aluControl, mem2Reg, origPc, isLoad, isStore
	);
endinterface

interface trapCtrlIf
	import controlPkg::*;
#(
	parameter int xlen = 32
)
();
	logic pcOrUtvec;
	logic csrWrite;
	logic [xlen-1:0] ucause;
	csrNumSelT selectNumRegCsr;
	csrDataSelT origWriteDataCsr;
	logic ebreak;

	modport request
	(
		output pcOrUtvec, csrWrite, ucause, selectNumRegCsr, origWriteDataCsr, ebreak
	);

	modport arbiter
	(
		input pcOrUtvec, csrWrite, ucause, selectNumRegCsr, origWriteDataCsr, ebreak
	);
endinterface

//--- design/controlPkg.sv
package controlPkg;

	typedef enum logic [6:0]
	{
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_RTYPE  = 7'b0110011,
		OPC_AUIPC  = 7'b0010111,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcodeT;

	// funct3 values repeat across instruction groups, so they are plain typed constants
	typedef logic [2:0] funct3T;

	localparam funct3T FUNCT3_ADD    = 3'b000;
	localparam funct3T FUNCT3_SLL    = 3'b001;
	localparam funct3T FUNCT3_SLT    = 3'b010;
	localparam funct3T FUNCT3_SLTU   = 3'b011;
	localparam funct3T FUNCT3_XOR    = 3'b100;
	localparam funct3T FUNCT3_SRL    = 3'b101; // also SRA, split by funct7
	localparam funct3T FUNCT3_OR     = 3'b110;
	localparam funct3T FUNCT3_AND    = 3'b111;
	localparam funct3T FUNCT3_MUL    = 3'b000;
	localparam funct3T FUNCT3_MULH   = 3'b001;
	localparam funct3T FUNCT3_MULHSU = 3'b010;
	localparam funct3T FUNCT3_MULHU  = 3'b011;
	localparam funct3T FUNCT3_DIV    = 3'b100;
	localparam funct3T FUNCT3_DIVU   = 3'b101;
	localparam funct3T FUNCT3_REM    = 3'b110;
	localparam funct3T FUNCT3_REMU   = 3'b111;
	localparam funct3T FUNCT3_ECALL  = 3'b000; // ecall, ebreak and uret
	localparam funct3T FUNCT3_CSRRW  = 3'b001;
	localparam funct3T FUNCT3_CSRRS  = 3'b010;
	localparam funct3T FUNCT3_CSRRC  = 3'b011;
	localparam funct3T FUNCT3_SYSRSV = 3'b100; // reserved in SYSTEM
	localparam funct3T FUNCT3_CSRRWI = 3'b101;
	localparam funct3T FUNCT3_CSRRSI = 3'b110;
	localparam funct3T FUNCT3_CSRRCI = 3'b111;

	typedef enum logic [6:0]
	{
		FUNCT7_BASE   = 7'b0000000,
		FUNCT7_ALT    = 7'b0100000, // sub, sra
		FUNCT7_MULDIV = 7'b0000001
	} funct7T;

	typedef enum logic [4:0]
	{
		ALU_NULL, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_MUL, ALU_MULH,
		ALU_MULHSU, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
	} aluOpT;

	typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEMORY, WB_CSR} mem2RegT;

	typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pcSourceT;

	typedef enum logic [1:0]
	{
		CSRNUM_INSTRUCTION = 2'd0,
		CSRNUM_UCAUSE      = 2'd1,
		CSRNUM_UEPC        = 2'd2
	} csrNumSelT;

	typedef enum logic [2:0]
	{
		CSRDATA_IMM, CSRDATA_PC, CSRDATA_INSTR, CSRDATA_RS1,
		CSRDATA_SET, CSRDATA_CLEAR, CSRDATA_SETIMM, CSRDATA_CLEARIMM
	} csrDataSelT;

	localparam int causeWidth = 4;
	localparam logic [4:0] RS2_URET = 5'b00010;

	typedef enum logic [causeWidth-1:0]
	{
		CAUSE_NONE       = 4'd0,
		CAUSE_TEXT       = 4'd1,
		CAUSE_ILLEGAL    = 4'd2,
		CAUSE_LOADFAULT  = 4'd4,
		CAUSE_LOADRANGE  = 4'd5,
		CAUSE_STOREFAULT = 4'd6,
		CAUSE_STORERANGE = 4'd7,
		CAUSE_ECALL      = 4'd8,
		CAUSE_CSR        = 4'd15
	} trapCauseT;

endpackage

//--- design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
	import controlPkg::*;
#(
	parameter int xlen = 32
)
(
	input  logic            clock,
	input  logic            reset,
	input  logic [31:0]     instr,
	input  logic            outText,
	input  logic            pcMisaligned,
	input  logic            exceptionLoad,
	input  logic            exceptionStore,
	input  logic            outData,
	output logic            origAUla,
	output logic            origBUla,
	output logic            regWrite,
	output logic            memWrite,
	output logic            memRead,
	output logic [4:0]      aluControl,
	output logic [1:0]      mem2Reg,
	output logic [1:0]      origPc,
	output logic            pcOrUtvec,
	output logic            csrWrite,
	output logic [xlen-1:0] ucause,
	output logic [1:0]      selectNumRegCsr,
	output logic [2:0]      origWriteDataCsr,
	output logic            ebreak
);

	datapathCtrlIf dpIf ();
	trapCtrlIf #(.xlen(xlen)) sysReqIf ();

	logic opcodeIllegal;
	logic functIllegal;
	logic systemIllegal;
	logic nextOrigAUla;
	logic nextOrigBUla;
	logic nextRegWrite;
	logic nextMemWrite;
	logic nextMemRead;
	aluOpT nextAluControl;
	mem2RegT nextMem2Reg;
	pcSourceT nextOrigPc;
	logic nextPcOrUtvec;
	logic nextCsrWrite;
	logic [xlen-1:0] nextUcause;
	csrNumSelT nextSelectNumRegCsr;
	csrDataSelT nextOrigWriteDataCsr;
	logic nextEbreak;

	mainDecoder i_mainDecoder (.instr(instr), .dp(dpIf), .opcodeIllegal(opcodeIllegal));

	aluOpDecoder i_aluOpDecoder (.instr(instr), .dp(dpIf), .functIllegal(functIllegal));

	systemDecoder i_systemDecoder (.instr(instr), .req(sysReqIf), .systemIllegal(systemIllegal));

	trapArbiter #(.xlen(xlen)) i_trapArbiter
	(
		.dp(dpIf), .req(sysReqIf),
		.opcodeIllegal(opcodeIllegal), .functIllegal(functIllegal),
		.systemIllegal(systemIllegal),
		.outText(outText), .pcMisaligned(pcMisaligned), .exceptionLoad(exceptionLoad),
		.exceptionStore(exceptionStore), .outData(outData),
		.origAUla(nextOrigAUla), .origBUla(nextOrigBUla), .regWrite(nextRegWrite),
		.memWrite(nextMemWrite), .memRead(nextMemRead), .aluControl(nextAluControl),
		.mem2Reg(nextMem2Reg), .origPc(nextOrigPc), .pcOrUtvec(nextPcOrUtvec),
		.csrWrite(nextCsrWrite), .ucause(nextUcause),
		.selectNumRegCsr(nextSelectNumRegCsr), .origWriteDataCsr(nextOrigWriteDataCsr),
		.ebreak(nextEbreak)
	);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			origAUla <= 1'b0;
			origBUla <= 1'b0;
			regWrite <= 1'b0;
			memWrite <= 1'b0;
			memRead <= 1'b0;
			aluControl <= ALU_NULL;
			mem2Reg <= WB_ALU;
			origPc <= PC_PLUS4;
			pcOrUtvec <= 1'b0;
			csrWrite <= 1'b0;
			ucause <= '0;
			selectNumRegCsr <= CSRNUM_INSTRUCTION;
			origWriteDataCsr <= CSRDATA_IMM;
			ebreak <= 1'b0;
		end
		else
		begin
			origAUla <= nextOrigAUla; // one cycle decode latency
			origBUla <= nextOrigBUla;
			regWrite <= nextRegWrite;
			memWrite <= nextMemWrite;
			memRead <= nextMemRead;
			aluControl <= nextAluControl;
			mem2Reg <= nextMem2Reg;
			origPc <= nextOrigPc;
			pcOrUtvec <= nextPcOrUtvec;
			csrWrite <= nextCsrWrite;
			ucause <= nextUcause;
			selectNumRegCsr <= nextSelectNumRegCsr;
			origWriteDataCsr <= nextOrigWriteDataCsr;
			ebreak <= nextEbreak;
		end
	end

endmodule

//--- design/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder
	import controlPkg::*;
(
	input  logic [31:0]    instr,
	datapathCtrlIf.decoder dp,
	output logic           opcodeIllegal
);

	opcodeT opcode;
	funct3T funct3;

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];

	always_comb
	begin
		dp.origAUla = 1'b0;
		dp.origBUla = 1'b0;
		dp.regWrite = 1'b0;
		dp.memWrite = 1'b0;
		dp.memRead = 1'b0;
		dp.mem2Reg = WB_ALU;
		dp.origPc = PC_PLUS4;
		dp.isLoad = 1'b0;
		dp.isStore = 1'b0;
		opcodeIllegal = 1'b0;
		case (opcode)
			OPC_LOAD:
			begin
				dp.origBUla = 1'b1; // base + offset
				dp.regWrite = 1'b1;
				dp.memRead = 1'b1;
				dp.mem2Reg = WB_MEMORY;
				dp.isLoad = 1'b1;
			end
			OPC_STORE:
			begin
				dp.origBUla = 1'b1;
				dp.memWrite = 1'b1;
				dp.isStore = 1'b1;
			end
			OPC_OPIMM, OPC_LUI:
			begin
				dp.origBUla = 1'b1; // immediate operand
				dp.regWrite = 1'b1;
			end
			OPC_RTYPE:
				dp.regWrite = 1'b1;
			OPC_AUIPC:
			begin
				dp.origAUla = 1'b1; // pc as operand A
				dp.origBUla = 1'b1;
				dp.regWrite = 1'b1;
			end
			OPC_BRANCH:
				dp.origPc = PC_BRANCH;
			OPC_JALR:
			begin
				dp.regWrite = 1'b1;
				dp.mem2Reg = WB_PC4; // link address
				dp.origPc = PC_JALR;
			end
			OPC_JAL:
			begin
				dp.regWrite = 1'b1;
				dp.mem2Reg = WB_PC4;
				dp.origPc = PC_JAL;
			end
			OPC_SYSTEM:
			begin
				// csr ops return the old csr value in rd
				dp.regWrite = (funct3 != FUNCT3_ECALL);
				dp.mem2Reg = WB_CSR;
			end
			default:
				opcodeIllegal = 1'b1;
		endcase
	end

endmodule

//--- design/systemDecoder.sv
`timescale 1ns/1ps

module systemDecoder
	import controlPkg::*;
(
	input  logic [31:0]    instr,
	trapCtrlIf.request     req,
	output logic           systemIllegal
);

	opcodeT opcode;
	funct3T funct3;
	logic [4:0] rs2;
	logic ebreakBit;
	trapCauseT cause;

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rs2 = instr[24:20];
	assign ebreakBit = instr[20]; // imm 1 selects ebreak

	always_comb
	begin
		req.pcOrUtvec = 1'b0;
		req.csrWrite = 1'b0;
		req.selectNumRegCsr = CSRNUM_INSTRUCTION;
		req.origWriteDataCsr = CSRDATA_IMM;
		req.ebreak = 1'b0;
		cause = CAUSE_NONE;
		systemIllegal = 1'b0;
		if (opcode == OPC_SYSTEM)
		begin
			case (funct3)
				FUNCT3_ECALL:
				begin
					if (ebreakBit)
						req.ebreak = 1'b1; // halt, no trap
					else if (rs2 == RS2_URET)
					begin
						req.pcOrUtvec = 1'b1; // return through uepc
						req.selectNumRegCsr = CSRNUM_UEPC;
					end
					else
					begin
						req.pcOrUtvec = 1'b1;
						req.csrWrite = 1'b1;
						req.selectNumRegCsr = CSRNUM_UCAUSE;
						req.origWriteDataCsr = CSRDATA_PC;
						cause = CAUSE_ECALL;
					end
				end
				FUNCT3_SYSRSV:
					systemIllegal = 1'b1;
				default:
				begin
					req.csrWrite = 1'b1;
					cause = CAUSE_CSR;
					case (funct3)
						FUNCT3_CSRRW:  req.origWriteDataCsr = CSRDATA_RS1;
						FUNCT3_CSRRS:  req.origWriteDataCsr = CSRDATA_SET;
						FUNCT3_CSRRC:  req.origWriteDataCsr = CSRDATA_CLEAR;
						FUNCT3_CSRRWI: req.origWriteDataCsr = CSRDATA_IMM;
						FUNCT3_CSRRSI: req.origWriteDataCsr = CSRDATA_SETIMM;
						FUNCT3_CSRRCI: req.origWriteDataCsr = CSRDATA_CLEARIMM;
						default:       req.origWriteDataCsr = CSRDATA_IMM;
					endcase
				end
			endcase
		end
		req.ucause = '0; // zero extend the cause code
		req.ucause[causeWidth-1:0] = cause;
	end

endmodule

//--- design/trapArbiter.sv
`timescale 1ns/1ps

module trapArbiter
	import controlPkg::*;
#(
	parameter int xlen = 32
)
(
	datapathCtrlIf.arbiter dp,
	trapCtrlIf.arbiter     req,
	input  logic            opcodeIllegal,
	input  logic            functIllegal,
	input  logic            systemIllegal,
	input  logic            outText,
	input  logic            pcMisaligned,
	input  logic            exceptionLoad,
	input  logic            exceptionStore,
	input  logic            outData,
	output logic            origAUla,
	output logic            origBUla,
	output logic            regWrite,
	output logic            memWrite,
	output logic            memRead,
	output aluOpT           aluControl,
	output mem2RegT         mem2Reg,
	output pcSourceT        origPc,
	output logic            pcOrUtvec,
	output logic            csrWrite,
	output logic [xlen-1:0] ucause,
	output csrNumSelT       selectNumRegCsr,
	output csrDataSelT      origWriteDataCsr,
	output logic            ebreak
);

	logic illegal;
	logic trapTaken;
	trapCauseT trapCause;
	csrDataSelT trapData;

	assign illegal = opcodeIllegal | functIllegal | systemIllegal;

	always_comb
	begin
		trapTaken = 1'b1;
		trapCause = CAUSE_NONE;
		trapData = CSRDATA_PC; // uepc gets the faulting pc
		if (outText)
			trapCause = CAUSE_TEXT;
		else if (pcMisaligned)
			trapCause = CAUSE_NONE; // misaligned fetch reports cause 0
		else if (illegal)
		begin
			trapCause = CAUSE_ILLEGAL;
			trapData = CSRDATA_INSTR;
		end
		else if (dp.isLoad && outData)
			trapCause = CAUSE_LOADRANGE;
		else if (dp.isStore && outData)
			trapCause = CAUSE_STORERANGE;
		else if (dp.isLoad && exceptionLoad)
			trapCause = CAUSE_LOADFAULT;
		else if (dp.isStore && exceptionStore)
			trapCause = CAUSE_STOREFAULT;
		else
			trapTaken = 1'b0;
	end

	always_comb
	begin
		if (trapTaken)
		begin
			origAUla = 1'b0;
			origBUla = 1'b0;
			regWrite = 1'b0; // no architectural side effects
			memWrite = 1'b0;
			memRead = 1'b0;
			aluControl = ALU_NULL;
			mem2Reg = WB_ALU;
			origPc = PC_PLUS4;
			pcOrUtvec = 1'b1; // jump to utvec
			csrWrite = 1'b1;
			ucause = xlen'(trapCause);
			selectNumRegCsr = CSRNUM_UCAUSE;
			origWriteDataCsr = trapData;
			ebreak = 1'b0;
		end
		else
		begin
			origAUla = dp.origAUla;
			origBUla = dp.origBUla;
			regWrite = dp.regWrite;
			memWrite = dp.memWrite;
			memRead = dp.memRead;
			aluControl = dp.aluControl;
			mem2Reg = dp.mem2Reg;
			origPc = dp.origPc;
			pcOrUtvec = req.pcOrUtvec; // ecall, uret or csr op
			csrWrite = req.csrWrite;
			ucause = req.ucause;
			selectNumRegCsr = req.selectNumRegCsr;
			origWriteDataCsr = req.origWriteDataCsr;
			ebreak = req.ebreak;
		end
	end

endmodule

//--- test/controlUnitInput.txt
// instr flags(outText pcMisaligned exceptionLoad exceptionStore outData) regWrite memWrite memRead
// aluControl origPc pcOrUtvec csrWrite ucause selectNumRegCsr ebreak; an all-zero line ends the list
003100B3 00 1 0 0 01 0 0 0 0 0 0 // add
403100B3 00 1 0 0 02 0 0 0 0 0 0 // sub
403150B3 00 1 0 0 08 0 0 0 0 0 0 // sra
023100B3 00 1 0 0 0C 0 0 0 0 0 0 // mul
023110B3 00 1 0 0 0D 0 0 0 0 0 0 // mulh
023120B3 00 1 0 0 0E 0 0 0 0 0 0 // mulhsu
023130B3 00 1 0 0 0F 0 0 0 0 0 0 // mulhu
023140B3 00 1 0 0 10 0 0 0 0 0 0 // div
023150B3 00 1 0 0 11 0 0 0 0 0 0 // divu
023160B3 00 1 0 0 12 0 0 0 0 0 0 // rem
023170B3 00 1 0 0 13 0 0 0 0 0 0 // remu
00510093 00 1 0 0 01 0 0 0 0 0 0 // addi
40315093 00 1 0 0 08 0 0 0 0 0 0 // srai
00514093 00 1 0 0 06 0 0 0 0 0 0 // xori
00412083 00 1 0 1 01 0 0 0 0 0 0 // lw
00312423 00 0 1 0 01 0 0 0 0 0 0 // sw
123450B7 00 1 0 0 0B 0 0 0 0 0 0 // lui
00001097 00 1 0 0 01 0 0 0 0 0 0 // auipc
00310063 00 0 0 0 01 1 0 0 0 0 0 // beq
000000EF 00 1 0 0 01 2 0 0 0 0 0 // jal
000100E7 00 1 0 0 01 3 0 0 0 0 0 // jalr
001110F3 00 1 0 0 00 0 0 1 F 0 0 // csrrw
001160F3 00 1 0 0 00 0 0 1 F 0 0 // csrrsi
00000073 00 0 0 0 00 0 1 1 8 1 0 // ecall
00100073 00 0 0 0 00 0 0 0 0 0 1 // ebreak
00200073 00 0 0 0 00 0 1 0 0 2 0 // uret
00412083 1D 0 0 0 00 0 1 1 1 1 0 // lw, text fault wins
00412083 0D 0 0 0 00 0 1 1 0 1 0 // lw, misaligned pc wins
00412083 05 0 0 0 00 0 1 1 5 1 0 // lw, range beats fault
00412083 04 0 0 0 00 0 1 1 4 1 0 // lw fault
00312423 03 0 0 0 00 0 1 1 7 1 0 // sw, range beats fault
00312423 02 0 0 0 00 0 1 1 6 1 0 // sw fault
003100B3 04 1 0 0 01 0 0 0 0 0 0 // add ignores load fault
0000007F 01 0 0 0 00 0 1 1 2 1 0 // unknown opcode
203100B3 00 0 0 0 00 0 1 1 2 1 0 // unknown funct7
001140F3 00 0 0 0 00 0 1 1 2 1 0 // reserved system funct3
0000007F 08 0 0 0 00 0 1 1 0 1 0 // misaligned beats illegal
00000000 00 0 0 0 00 0 0 0 0 0 0

//--- test/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	localparam int xlen = 32;
	localparam int fieldsPerVector = 12; // columns per line of the vector file
	localparam int maxVectors = 64;
	localparam int clockPeriod = 4;
	localparam int resetCycles = 4;

	logic clock;
	logic reset;
	logic [31:0] instr;
	logic outText;
	logic pcMisaligned;
	logic exceptionLoad;
	logic exceptionStore;
	logic outData;
	logic origAUla;
	logic origBUla;
	logic regWrite;
	logic memWrite;
	logic memRead;
	logic [4:0] aluControl;
	logic [1:0] mem2Reg;
	logic [1:0] origPc;
	logic pcOrUtvec;
	logic csrWrite;
	logic [xlen-1:0] ucause;
	logic [1:0] selectNumRegCsr;
	logic [2:0] origWriteDataCsr;
	logic ebreak;

	logic [31:0] vecMem [0:fieldsPerVector*maxVectors-1];
	int vectorCount;
	int errorCount;
	logic vectorsLoaded;

	controlUnit #(.xlen(xlen)) i_controlUnit
	(
		.clock(clock), .reset(reset), .instr(instr),
		.outText(outText), .pcMisaligned(pcMisaligned), .exceptionLoad(exceptionLoad),
		.exceptionStore(exceptionStore), .outData(outData),
		.origAUla(origAUla), .origBUla(origBUla), .regWrite(regWrite),
		.memWrite(memWrite), .memRead(memRead), .aluControl(aluControl),
		.mem2Reg(mem2Reg), .origPc(origPc), .pcOrUtvec(pcOrUtvec),
		.csrWrite(csrWrite), .ucause(ucause), .selectNumRegCsr(selectNumRegCsr),
		.origWriteDataCsr(origWriteDataCsr), .ebreak(ebreak)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	task automatic compareValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH %s expected %0h actual %0h", testName, expected, actual);
		end
	endtask

	// an all-zero instruction word closes the list
	function automatic logic isEndOfList(input int n);
		logic [31:0] word;
		word = vecMem[n * fieldsPerVector];
		return $isunknown(word) || (word == 32'h0);
	endfunction

	task automatic applyVector(input int n);
		logic [31:0] flags;
		flags = vecMem[n * fieldsPerVector + 1];
		instr = vecMem[n * fieldsPerVector];
		outText = flags[4];
		pcMisaligned = flags[3];
		exceptionLoad = flags[2];
		exceptionStore = flags[1];
		outData = flags[0];
	endtask

	task automatic checkResetOutputs();
		compareValue("reset origAUla", 32'h0, 32'(origAUla));
		compareValue("reset origBUla", 32'h0, 32'(origBUla));
		compareValue("reset regWrite", 32'h0, 32'(regWrite));
		compareValue("reset memWrite", 32'h0, 32'(memWrite));
		compareValue("reset memRead", 32'h0, 32'(memRead));
		compareValue("reset aluControl", 32'h0, 32'(aluControl)); // null op
		compareValue("reset mem2Reg", 32'h0, 32'(mem2Reg));
		compareValue("reset origPc", 32'h0, 32'(origPc));
		compareValue("reset pcOrUtvec", 32'h0, 32'(pcOrUtvec));
		compareValue("reset csrWrite", 32'h0, 32'(csrWrite));
		compareValue("reset ucause", 32'h0, ucause);
		compareValue("reset selectNumRegCsr", 32'h0, 32'(selectNumRegCsr));
		compareValue("reset origWriteDataCsr", 32'h0, 32'(origWriteDataCsr));
		compareValue("reset ebreak", 32'h0, 32'(ebreak));
	endtask

	task automatic checkVector(input int n);
		int base;
		string tag;
		base = n * fieldsPerVector;
		tag = $sformatf("vector%0d(%08h)", n, vecMem[base]);
		compareValue({tag, " regWrite"}, vecMem[base + 2], 32'(regWrite));
		compareValue({tag, " memWrite"}, vecMem[base + 3], 32'(memWrite));
		compareValue({tag, " memRead"}, vecMem[base + 4], 32'(memRead));
		compareValue({tag, " aluControl"}, vecMem[base + 5], 32'(aluControl));
		compareValue({tag, " origPc"}, vecMem[base + 6], 32'(origPc));
		compareValue({tag, " pcOrUtvec"}, vecMem[base + 7], 32'(pcOrUtvec));
		compareValue({tag, " csrWrite"}, vecMem[base + 8], 32'(csrWrite));
		compareValue({tag, " ucause"}, vecMem[base + 9], ucause);
		compareValue({tag, " selectNumRegCsr"}, vecMem[base + 10], 32'(selectNumRegCsr));
		compareValue({tag, " ebreak"}, vecMem[base + 11], 32'(ebreak));
	endtask

	// budget grows with the vector list
	initial
	begin
		wait (vectorsLoaded === 1'b1);
		#(vectorCount * clockPeriod + 200);
		$display("timeout: the vector list did not finish in the allowed time");
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		int n;
		int assertFails;
		errorCount = 0;
		vectorCount = 0;
		vectorsLoaded = 1'b0;
		reset = 1'b1;
		instr = 32'h0;
		outText = 1'b0;
		pcMisaligned = 1'b0;
		exceptionLoad = 1'b0;
		exceptionStore = 1'b0;
		outData = 1'b0;
		$readmemh("test/controlUnitInput.txt", vecMem);
		while (vectorCount < maxVectors && !isEndOfList(vectorCount))
			vectorCount++;
		if (vectorCount == 0)
		begin
			errorCount++;
			$display("no vectors were read from test/controlUnitInput.txt");
		end
		vectorsLoaded = 1'b1;

		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		checkResetOutputs(); // reset still high here
		reset = 1'b0;

		for (n = 0; n < vectorCount; n++)
		begin
			applyVector(n); // on the falling edge
			@(negedge clock);
			checkVector(n); // registered one rising edge later
		end
		@(negedge clock); // one more rising edge so the assertions see the last outputs

		assertFails = int'(i_controlUnit.i_properties.failCount);
		$display("summary: %0d vectors, %0d mismatches, %0d assertion failures",
			vectorCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- test/controlUnit_properties.sv
`timescale 1ns/1ps

module controlUnitProperties
(
	input logic clock,
	input logic reset,
	input logic regWrite,
	input logic memWrite,
	input logic memRead,
	input logic pcOrUtvec,
	input logic csrWrite,
	input logic ebreak
);

	int unsigned failCount = 0; // summed into the testbench result

	trapBlocksWrites: assert property (@(posedge clock) disable iff (reset)
		pcOrUtvec |-> !regWrite && !memWrite)
	else
	begin
		failCount++;
		$error("jump to utvec with a register or memory write enabled");
	end

	// outputs cleared on the cycle after a reset edge
	resetClearsEnables: assert property (@(posedge clock)
		reset |=> !regWrite && !memWrite && !memRead && !csrWrite && !pcOrUtvec)
	else
	begin
		failCount++;
		$error("an enable is high on the cycle after reset");
	end

	ebreakNoCsrWrite: assert property (@(posedge clock) disable iff (reset)
		!(ebreak && csrWrite))
	else
	begin
		failCount++;
		$error("ebreak raised together with a csr write");
	end

endmodule

bind controlUnit controlUnitProperties i_properties
(
	.clock(clock), .reset(reset), .regWrite(regWrite), .memWrite(memWrite),
	.memRead(memRead), .pcOrUtvec(pcOrUtvec), .csrWrite(csrWrite), .ebreak(ebreak)
);
